// File: hdl/rv_exec_pkg.sv
// shared RV64IM types; mulh* and stores are not decoded and the ALU codes follow the 5-bit reference set
`default_nettype none

package rv_exec_pkg;

  localparam int NREGS_DEFAULT = 32;

  // major opcodes
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

  localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

  // operand B select
  localparam logic [1:0] BSEL_RS2  = 2'd0;
  localparam logic [1:0] BSEL_IMM  = 2'd1;
  localparam logic [1:0] BSEL_FOUR = 2'd2;

  typedef enum logic [4:0] {
    ALU_ADD  = 5'b00000,
    ALU_SLL  = 5'b00001,
    ALU_SLT  = 5'b00010,
    ALU_COPY = 5'b00011,
    ALU_XOR  = 5'b00100,
    ALU_SRL  = 5'b00101,
    ALU_OR   = 5'b00110,
    ALU_AND  = 5'b00111,
    ALU_SUB  = 5'b01000,
    ALU_SLTU = 5'b01010,
    ALU_SRA  = 5'b01101,
    ALU_REMU = 5'b11001,
    ALU_DIVU = 5'b11010,
    ALU_DIV  = 5'b11011,
    ALU_MUL  = 5'b11100,
    ALU_REM  = 5'b11101
  } alu_op_e;

  // signed or unsigned compare comes from the alu op
  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_EQ   = 3'b100,
    BR_NE   = 3'b101,
    BR_LT   = 3'b110,
    BR_GE   = 3'b111
  } branch_e;

  typedef enum logic [2:0] {
    MEM_LB  = 3'b000,
    MEM_LBU = 3'b001,
    MEM_LH  = 3'b010,
    MEM_LHU = 3'b011,
    MEM_LW  = 3'b100,
    MEM_LWU = 3'b101,
    MEM_LD  = 3'b110
  } mem_op_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       a_is_pc;
    logic [1:0] b_sel;
    logic       word_cut;
    branch_e    branch;
    mem_op_e    mem_op;
    logic       mem_to_reg;
    logic       reg_write;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       is_ebreak;
    logic       is_illegal;
  } ctrl_t;

  typedef struct packed {
    logic [63:0] alu_result;
    logic [63:0] next_pc;
    logic        branch_taken;
    logic [63:0] link;
  } exec_res_t;

endpackage

`default_nettype wire

// File: hdl/inst_decoder.sv
// RV64IM decode only; stores, fence, ecall, csr ops and mulh* come out as illegal
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import rv_exec_pkg::*; (
  input  logic [31:0] i_inst,
  output ctrl_t       o_ctrl,
  output logic [63:0] o_imm
);

  logic [6:0]  opcode;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        is_w;
  logic        shift_ok;
  logic        w_f3_ok;
  logic [63:0] imm_i;
  logic [63:0] imm_u;
  logic [63:0] imm_j;
  logic [63:0] imm_b;

  assign opcode = i_inst[6:0];
  assign f3     = i_inst[14:12];
  assign f7     = i_inst[31:25];
  // OP-32 and OP-IMM-32 differ from their 64-bit forms in bit 3
  assign is_w   = opcode[3];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'd0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};

  // shamt field upper bits must be clear, bit 30 only for right shifts
  assign shift_ok = !i_inst[31] && (i_inst[29:26] == 4'd0) && (f3 == 3'b101 || !i_inst[30])
                    && (!is_w || !i_inst[25]);
  assign w_f3_ok  = (f3 == 3'b000) || (f3 == 3'b001) || (f3 == 3'b101);

  function automatic alu_op_e base_op(input logic [2:0] fn, input logic alt);
    case (fn)
      3'b000:  base_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  base_op = ALU_SLL;
      3'b010:  base_op = ALU_SLT;
      3'b011:  base_op = ALU_SLTU;
      3'b100:  base_op = ALU_XOR;
      3'b101:  base_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  base_op = ALU_OR;
      default: base_op = ALU_AND;
    endcase
  endfunction

  always_comb begin
    o_ctrl         = '0;
    o_ctrl.alu_op  = ALU_ADD;
    o_ctrl.b_sel   = BSEL_RS2;
    o_ctrl.branch  = BR_NONE;
    o_ctrl.mem_op  = MEM_LD;
    o_ctrl.rd      = i_inst[11:7];
    o_ctrl.rs1     = i_inst[19:15];
    o_ctrl.rs2     = i_inst[24:20];
    o_imm          = imm_i;
    case (opcode)
      OPC_OP, OPC_OP_32: begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.word_cut  = is_w;
        if (f7 == 7'b0000001) begin
          case (f3)
            3'b000:  o_ctrl.alu_op = ALU_MUL;
            3'b100:  o_ctrl.alu_op = ALU_DIV;
            3'b101:  o_ctrl.alu_op = ALU_DIVU;
            3'b110:  o_ctrl.alu_op = ALU_REM;
            3'b111:  o_ctrl.alu_op = ALU_REMU;
            default: o_ctrl.is_illegal = 1'b1;
          endcase
          if (is_w && f3 != 3'b000 && !f3[2]) o_ctrl.is_illegal = 1'b1;
        end else if (f7 == 7'b0000000 || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101))) begin
          o_ctrl.alu_op = base_op(f3, f7[5]);
          if (is_w && !w_f3_ok) o_ctrl.is_illegal = 1'b1;
        end else begin
          o_ctrl.is_illegal = 1'b1;
        end
      end
      OPC_OP_IMM, OPC_OP_IMM_32: begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.word_cut  = is_w;
        o_ctrl.b_sel     = BSEL_IMM;
        o_ctrl.alu_op    = base_op(f3, (f3 == 3'b101) && i_inst[30]);
        if ((f3 == 3'b001 || f3 == 3'b101) && !shift_ok) o_ctrl.is_illegal = 1'b1;
        if (is_w && !w_f3_ok) o_ctrl.is_illegal = 1'b1;
      end
      OPC_LUI: begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_op    = ALU_COPY;
        o_ctrl.b_sel     = BSEL_IMM;
        o_imm            = imm_u;
      end
      OPC_AUIPC: begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.a_is_pc   = 1'b1;
        o_ctrl.b_sel     = BSEL_IMM;
        o_imm            = imm_u;
      end
      OPC_JAL, OPC_JALR: begin
        // link value pc + 4 goes through the ALU
        o_ctrl.reg_write = 1'b1;
        o_ctrl.a_is_pc   = 1'b1;
        o_ctrl.b_sel     = BSEL_FOUR;
        o_ctrl.branch    = opcode[3] ? BR_JAL : BR_JALR;
        o_imm            = opcode[3] ? imm_j : imm_i;
        if (!opcode[3] && f3 != 3'b000) o_ctrl.is_illegal = 1'b1;
      end
      OPC_BRANCH: begin
        o_imm         = imm_b;
        o_ctrl.alu_op = !f3[2] ? ALU_SUB : (f3[1] ? ALU_SLTU : ALU_SLT);
        case (f3)
          3'b000:         o_ctrl.branch = BR_EQ;
          3'b001:         o_ctrl.branch = BR_NE;
          3'b100, 3'b110: o_ctrl.branch = BR_LT;
          3'b101, 3'b111: o_ctrl.branch = BR_GE;
          default:        o_ctrl.is_illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        o_ctrl.reg_write  = 1'b1;
        o_ctrl.mem_to_reg = 1'b1;
        o_ctrl.b_sel      = BSEL_IMM;
        case (f3)
          3'b000:  o_ctrl.mem_op = MEM_LB;
          3'b001:  o_ctrl.mem_op = MEM_LH;
          3'b010:  o_ctrl.mem_op = MEM_LW;
          3'b011:  o_ctrl.mem_op = MEM_LD;
          3'b100:  o_ctrl.mem_op = MEM_LBU;
          3'b101:  o_ctrl.mem_op = MEM_LHU;
          3'b110:  o_ctrl.mem_op = MEM_LWU;
          default: o_ctrl.is_illegal = 1'b1;
        endcase
      end
      OPC_SYSTEM: begin
        if (i_inst == INST_EBREAK) o_ctrl.is_ebreak = 1'b1;
        else o_ctrl.is_illegal = 1'b1;
      end
      default: o_ctrl.is_illegal = 1'b1;
    endcase
    if (o_ctrl.is_illegal) o_ctrl.reg_write = 1'b0;
  end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
// NREGS x 64 register file, NREGS at most 32; x0 reads zero and indices past NREGS read zero
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
  parameter int NREGS = 32
) (
  input  logic        i_clk,
  input  logic        i_arst_n,
  input  logic [4:0]  i_rs1_idx,
  input  logic [4:0]  i_rs2_idx,
  output logic [63:0] o_rs1,
  output logic [63:0] o_rs2,
  input  logic        i_we,
  input  logic [4:0]  i_wr_idx,
  input  logic [63:0] i_wr_data
);

  localparam int IW = $clog2(NREGS);

  logic [63:0] regs [NREGS];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_wr_idx != 5'd0 && i_wr_idx < NREGS) begin
      regs[i_wr_idx[IW-1:0]] <= i_wr_data;
    end
  end

  // x0 is never written so it stays zero
  assign o_rs1 = (i_rs1_idx < NREGS) ? regs[i_rs1_idx[IW-1:0]] : 64'd0;
  assign o_rs2 = (i_rs2_idx < NREGS) ? regs[i_rs2_idx[IW-1:0]] : 64'd0;

endmodule

`default_nettype wire

// File: hdl/alu.sv
// single-cycle 64-bit ALU with combinational divide; W forms take the low word and sign-extend bit 31
`timescale 1ns/1ps
`default_nettype none

module alu import rv_exec_pkg::*; (
  input  alu_op_e     i_op,
  input  logic        i_word_cut,
  input  logic [63:0] i_a,
  input  logic [63:0] i_b,
  input  logic [63:0] i_imm,
  output logic [63:0] o_result,
  output logic        o_zero,
  output logic        o_less
);

  logic               sext_op;
  logic [63:0]        a;
  logic [63:0]        b;
  logic [5:0]         shamt;
  logic [63:0]        diff;
  logic               div_zero;
  logic               div_ovf;
  logic [63:0]        quot;
  logic [63:0]        rem_v;
  logic signed [63:0] sra64;
  logic signed [31:0] sra32;
  logic [63:0]        raw;

  // divw and remw need the sign of the low word kept
  assign sext_op = (i_op == ALU_DIV) || (i_op == ALU_REM);

  assign a = !i_word_cut ? i_a :
             sext_op     ? {{32{i_a[31]}}, i_a[31:0]} : {32'd0, i_a[31:0]};
  assign b = !i_word_cut ? i_b :
             sext_op     ? {{32{i_b[31]}}, i_b[31:0]} : {32'd0, i_b[31:0]};

  assign shamt = i_word_cut ? {1'b0, b[4:0]} : b[5:0];

  assign diff   = a - b;
  assign o_zero = (diff == 64'd0);
  assign o_less = (i_op == ALU_SLTU) ? (a < b) : ($signed(a) < $signed(b));

  assign sra64 = $signed(a) >>> shamt;
  assign sra32 = $signed(a[31:0]) >>> shamt[4:0];

  assign div_zero = (b == 64'd0);
  assign div_ovf  = (a == {1'b1, 63'd0}) && (b == {64{1'b1}});

  // divide by zero gives all ones and leaves the dividend as remainder
  always_comb begin
    quot  = {64{1'b1}};
    rem_v = a;
    if (!div_zero) begin
      if (i_op == ALU_DIVU || i_op == ALU_REMU) begin
        quot  = a / b;
        rem_v = a % b;
      end else if (div_ovf) begin
        quot  = a;
        rem_v = 64'd0;
      end else begin
        quot  = $signed(a) / $signed(b);
        rem_v = $signed(a) % $signed(b);
      end
    end
  end

  always_comb begin
    case (i_op)
      ALU_COPY: raw = i_imm;
      ALU_ADD:  raw = a + b;
      ALU_SUB:  raw = diff;
      ALU_SLT:  raw = {63'd0, o_less};
      ALU_SLTU: raw = {63'd0, o_less};
      ALU_XOR:  raw = a ^ b;
      ALU_AND:  raw = a & b;
      ALU_OR:   raw = a | b;
      ALU_SLL:  raw = a << shamt;
      ALU_SRL:  raw = a >> shamt;
      ALU_SRA:  raw = i_word_cut ? {32'd0, sra32} : sra64;
      ALU_MUL:  raw = a * b;
      ALU_DIV, ALU_DIVU: raw = quot;
      ALU_REM, ALU_REMU: raw = rem_v;
      default:  raw = 64'd0;
    endcase
  end

  assign o_result = i_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
// operand muxing and next-pc logic; misaligned branch targets are not checked
`timescale 1ns/1ps
`default_nettype none

module exec_unit import rv_exec_pkg::*; (
  input  ctrl_t       i_ctrl,
  input  logic [63:0] i_imm,
  input  logic [63:0] i_pc,
  input  logic [63:0] i_rs1,
  input  logic [63:0] i_rs2,
  output exec_res_t   o_res
);

  logic [63:0] op_a;
  logic [63:0] op_b;
  logic [63:0] alu_out;
  logic        zero;
  logic        less;
  logic        taken;
  logic [63:0] jalr_target;

  assign op_a = i_ctrl.a_is_pc ? i_pc : i_rs1;

  always_comb begin
    case (i_ctrl.b_sel)
      BSEL_IMM:  op_b = i_imm;
      BSEL_FOUR: op_b = 64'd4;
      default:   op_b = i_rs2;
    endcase
  end

  alu u_alu (
    .i_op       (i_ctrl.alu_op),
    .i_word_cut (i_ctrl.word_cut),
    .i_a        (op_a),
    .i_b        (op_b),
    .i_imm      (i_imm),
    .o_result   (alu_out),
    .o_zero     (zero),
    .o_less     (less)
  );

  // compare branches ride on the subtract pass
  always_comb begin
    case (i_ctrl.branch)
      BR_JAL, BR_JALR: taken = 1'b1;
      BR_EQ:           taken = zero;
      BR_NE:           taken = !zero;
      BR_LT:           taken = less;
      BR_GE:           taken = !less;
      default:         taken = 1'b0;
    endcase
  end

  assign jalr_target = i_rs1 + i_imm;

  assign o_res.alu_result   = alu_out;
  assign o_res.branch_taken = taken;
  assign o_res.link         = i_pc + 64'd4;
  assign o_res.next_pc      = (i_ctrl.branch == BR_JALR) ? {jalr_target[63:1], 1'b0} :
                              taken                      ? i_pc + i_imm : i_pc + 64'd4;

endmodule

`default_nettype wire

// File: hdl/writeback_unit.sv
// one-cycle write-back stage; halt and illegal stay set until reset but do not stop later instructions
`timescale 1ns/1ps
`default_nettype none

module writeback_unit import rv_exec_pkg::*; (
  input  logic        i_clk,
  input  logic        i_arst_n,
  input  logic        i_valid,
  input  ctrl_t       i_ctrl,
  input  exec_res_t   i_res,
  input  logic [63:0] i_rdata,
  output logic        o_rf_we,
  output logic [4:0]  o_rf_idx,
  output logic [63:0] o_rf_data,
  output logic        o_valid,
  output logic [4:0]  o_rd,
  output logic        o_wb_en,
  output logic [63:0] o_wb_data,
  output logic [63:0] o_next_pc,
  output logic        o_halt,
  output logic        o_illegal
);

  logic [63:0] load_data;

  always_comb begin
    case (i_ctrl.mem_op)
      MEM_LB:  load_data = {{56{i_rdata[7]}}, i_rdata[7:0]};
      MEM_LBU: load_data = {56'd0, i_rdata[7:0]};
      MEM_LH:  load_data = {{48{i_rdata[15]}}, i_rdata[15:0]};
      MEM_LHU: load_data = {48'd0, i_rdata[15:0]};
      MEM_LW:  load_data = {{32{i_rdata[31]}}, i_rdata[31:0]};
      MEM_LWU: load_data = {32'd0, i_rdata[31:0]};
      default: load_data = i_rdata;
    endcase
  end

  assign o_rf_we   = i_valid && i_ctrl.reg_write && !i_ctrl.is_ebreak && !i_ctrl.is_illegal;
  assign o_rf_idx  = i_ctrl.rd;
  assign o_rf_data = i_ctrl.mem_to_reg ? load_data :
                     (i_ctrl.branch == BR_JAL || i_ctrl.branch == BR_JALR) ? i_res.link :
                     i_res.alu_result;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid   <= 1'b0;
      o_wb_en   <= 1'b0;
      o_halt    <= 1'b0;
      o_illegal <= 1'b0;
    end else begin
      o_valid <= i_valid;
      o_wb_en <= o_rf_we;
      // sticky
      if (i_valid && i_ctrl.is_ebreak) o_halt <= 1'b1;
      if (i_valid && i_ctrl.is_illegal) o_illegal <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_rd      <= i_ctrl.rd;
      o_wb_data <= o_rf_data;
      o_next_pc <= i_res.next_pc;
    end
  end

endmodule

`default_nettype wire

// File: hdl/exec_core_top.sv
// RV64IM execute core, one instruction per cycle with one-cycle latency; no fetch, stores or traps
`timescale 1ns/1ps
`default_nettype none

module exec_core_top import rv_exec_pkg::*; #(
  parameter int NREGS = NREGS_DEFAULT
) (
  input  logic        i_clk,
  input  logic        i_arst_n,
  input  logic        i_valid,
  input  logic [31:0] i_inst,
  input  logic [63:0] i_pc,
  input  logic [63:0] i_rdata,
  output logic        o_valid,
  output logic [4:0]  o_rd,
  output logic        o_wb_en,
  output logic [63:0] o_wb_data,
  output logic [63:0] o_next_pc,
  output logic        o_halt,
  output logic        o_illegal
);

  ctrl_t       ctrl;
  exec_res_t   res;
  logic [63:0] imm;
  logic [63:0] rs1_val;
  logic [63:0] rs2_val;
  logic        rf_we;
  logic [4:0]  rf_idx;
  logic [63:0] rf_data;

  inst_decoder u_dec (
    .i_inst (i_inst),
    .o_ctrl (ctrl),
    .o_imm  (imm)
  );

  reg_file #(.NREGS(NREGS)) u_rf (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_rs1_idx (ctrl.rs1),
    .i_rs2_idx (ctrl.rs2),
    .o_rs1     (rs1_val),
    .o_rs2     (rs2_val),
    .i_we      (rf_we),
    .i_wr_idx  (rf_idx),
    .i_wr_data (rf_data)
  );

  exec_unit u_exu (
    .i_ctrl (ctrl),
    .i_imm  (imm),
    .i_pc   (i_pc),
    .i_rs1  (rs1_val),
    .i_rs2  (rs2_val),
    .o_res  (res)
  );

  writeback_unit u_wbu (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (i_valid),
    .i_ctrl    (ctrl),
    .i_res     (res),
    .i_rdata   (i_rdata),
    .o_rf_we   (rf_we),
    .o_rf_idx  (rf_idx),
    .o_rf_data (rf_data),
    .o_valid   (o_valid),
    .o_rd      (o_rd),
    .o_wb_en   (o_wb_en),
    .o_wb_data (o_wb_data),
    .o_next_pc (o_next_pc),
    .o_halt    (o_halt),
    .o_illegal (o_illegal)
  );

endmodule

`default_nettype wire

// File: bench/tb_exec_core.sv
// bench for a 32-register core; the model covers only the RV64IM forms generated here
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;

  localparam int N_INIT   = 62;
  localparam int N_ALU    = 300;
  localparam int N_BRANCH = 80;
  localparam int N_LOAD   = 60;
  localparam int N_FLAGS  = 6;
  localparam int N_TOTAL  = N_INIT + N_ALU + N_BRANCH + N_LOAD + N_FLAGS;
  localparam int LIMIT    = N_TOTAL + 50;

  typedef struct packed {
    logic [4:0]  rd;
    logic        wb_en;
    logic [63:0] wb_data;
    logic [63:0] next_pc;
    logic        halt;
    logic        illegal;
  } exp_t;

  logic        i_clk;
  logic        i_arst_n;
  logic        i_valid;
  logic [31:0] i_inst;
  logic [63:0] i_pc;
  logic [63:0] i_rdata;
  logic        o_valid;
  logic [4:0]  o_rd;
  logic        o_wb_en;
  logic [63:0] o_wb_data;
  logic [63:0] o_next_pc;
  logic        o_halt;
  logic        o_illegal;

  logic [63:0] shadow [32];
  exp_t        exp_q [$];
  string       test_name;
  int          errors;
  int          checked;
  int          cycles;
  logic        run_started;
  logic        sticky_halt;
  logic        sticky_ill;
  logic [4:0]  last_rd;
  logic        valid_d;

  exec_core_top #(.NREGS(32)) DUT (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (i_valid),
    .i_inst    (i_inst),
    .i_pc      (i_pc),
    .i_rdata   (i_rdata),
    .o_valid   (o_valid),
    .o_rd      (o_rd),
    .o_wb_en   (o_wb_en),
    .o_wb_data (o_wb_data),
    .o_next_pc (o_next_pc),
    .o_halt    (o_halt),
    .o_illegal (o_illegal)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  function automatic logic [63:0] sext32(input logic [63:0] v);
    return {{32{v[31]}}, v[31:0]};
  endfunction

  function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] a, input logic [63:0] b,
                                          input logic w);
    logic [5:0]         sh;
    logic signed [31:0] s32;
    logic signed [63:0] s64;
    logic [63:0]        r;
    sh  = w ? {1'b0, b[4:0]} : b[5:0];
    s32 = a[31:0];
    s64 = a;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << sh;
      3'd2: r = {63'd0, $signed(a) < $signed(b)};
      3'd3: r = {63'd0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt && w) r = {32'd0, s32 >>> sh[4:0]};
        else if (alt) r = s64 >>> sh;
        else if (w) r = {32'd0, a[31:0]} >> sh;
        else r = a >> sh;
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return w ? sext32(r) : r;
  endfunction

  function automatic logic [63:0] muldiv_ref(input logic [2:0] f3, input logic [63:0] a_in,
                                             input logic [63:0] b_in, input logic w);
    logic               sgn;
    logic [63:0]        a;
    logic [63:0]        b;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        r;
    sgn = (f3 == 3'd4) || (f3 == 3'd6);
    a   = !w ? a_in : (sgn ? sext32(a_in) : {32'd0, a_in[31:0]});
    b   = !w ? b_in : (sgn ? sext32(b_in) : {32'd0, b_in[31:0]});
    sa  = a;
    sb  = b;
    if (f3 == 3'd0) r = a * b;
    else if (b == 64'd0) r = f3[1] ? a : {64{1'b1}};
    else if (sgn && a == {1'b1, 63'd0} && b == {64{1'b1}}) r = f3[1] ? 64'd0 : a;
    else begin
      case (f3)
        3'd4:    r = sa / sb;
        3'd5:    r = a / b;
        3'd6:    r = sa % sb;
        default: r = a % b;
      endcase
    end
    return w ? sext32(r) : r;
  endfunction

  function automatic exp_t ref_model(input logic [63:0] rf [32], input logic [31:0] inst,
                                     input logic [63:0] pc, input logic [63:0] rdata);
    exp_t        e;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] immi;
    logic [63:0] immu;
    logic [63:0] immj;
    logic [63:0] immb;
    logic        cond;
    opc  = inst[6:0];
    f3   = inst[14:12];
    a    = rf[inst[19:15]];
    b    = rf[inst[24:20]];
    immi = {{52{inst[31]}}, inst[31:20]};
    immu = {{32{inst[31]}}, inst[31:12], 12'd0};
    immj = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    immb = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    e         = '0;
    e.rd      = inst[11:7];
    e.next_pc = pc + 64'd4;
    e.wb_en   = 1'b1;
    case (opc)
      7'h33, 7'h3b: begin
        if (inst[31:25] == 7'd1) e.wb_data = muldiv_ref(f3, a, b, opc[3]);
        else e.wb_data = alu_ref(f3, inst[30], a, b, opc[3]);
      end
      7'h13, 7'h1b: e.wb_data = alu_ref(f3, (f3 == 3'd5) && inst[30], a, immi, opc[3]);
      7'h37: e.wb_data = immu;
      7'h17: e.wb_data = pc + immu;
      7'h6f: begin
        e.wb_data = pc + 64'd4;
        e.next_pc = pc + immj;
      end
      7'h67: begin
        e.wb_data = pc + 64'd4;
        e.next_pc = (a + immi) & ~64'd1;
      end
      7'h63: begin
        e.wb_en = 1'b0;
        case (f3)
          3'd0:    cond = (a == b);
          3'd1:    cond = (a != b);
          3'd4:    cond = $signed(a) < $signed(b);
          3'd5:    cond = $signed(a) >= $signed(b);
          3'd6:    cond = a < b;
          default: cond = a >= b;
        endcase
        if (cond) e.next_pc = pc + immb;
      end
      7'h03: begin
        case (f3)
          3'd0:    e.wb_data = {{56{rdata[7]}}, rdata[7:0]};
          3'd1:    e.wb_data = {{48{rdata[15]}}, rdata[15:0]};
          3'd2:    e.wb_data = {{32{rdata[31]}}, rdata[31:0]};
          3'd4:    e.wb_data = {56'd0, rdata[7:0]};
          3'd5:    e.wb_data = {48'd0, rdata[15:0]};
          3'd6:    e.wb_data = {32'd0, rdata[31:0]};
          default: e.wb_data = rdata;
        endcase
      end
      default: begin
        e.wb_en = 1'b0;
        if (inst == 32'h0010_0073) e.halt = 1'b1;
        else e.illegal = 1'b1;
      end
    endcase
    return e;
  endfunction

  // instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic issue(input logic [31:0] inst, input logic [63:0] pc,
                       input logic [63:0] rdata);
    exp_t e;
    @(posedge i_clk);
    i_valid <= 1'b1;
    i_inst  <= inst;
    i_pc    <= pc;
    i_rdata <= rdata;
    e = ref_model(shadow, inst, pc, rdata);
    sticky_halt = sticky_halt | e.halt;
    sticky_ill  = sticky_ill | e.illegal;
    e.halt      = sticky_halt;
    e.illegal   = sticky_ill;
    if (e.wb_en && e.rd != 5'd0) shadow[e.rd] = e.wb_data;
    last_rd = e.rd;
    exp_q.push_back(e);
  endtask

  task automatic finish_test(input int err_start, input int count);
    @(posedge i_clk);
    i_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge i_clk);
    $display("test %s: %0d instructions, %0d errors", test_name, count, errors - err_start);
  endtask

  function automatic logic [4:0] pick_reg();
    return 5'($urandom_range(31, 0));
  endfunction

  task automatic random_alu();
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    int          kind;
    rs1  = ($urandom_range(3, 0) == 0) ? last_rd : pick_reg();
    rs2  = ($urandom_range(7, 0) == 0) ? 5'd0 : pick_reg();
    kind = $urandom_range(5, 0);
    imm  = 12'($urandom);
    case (kind)
      0, 2: begin
        f3 = (kind == 0) ? 3'($urandom) : 3'(2 * $urandom_range(1, 0) * 2 + $urandom_range(1, 0));
        if (kind == 2 && f3 > 3'd1 && f3 != 3'd5) f3 = 3'd0;
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
        issue(enc_r(f7, rs2, rs1, f3, pick_reg(), kind == 0 ? 7'h33 : 7'h3b), 64'd0, 64'd0);
      end
      1, 3: begin
        f3 = 3'($urandom_range(4, 0));
        if (f3 != 3'd0) f3 = f3 + 3'd3;
        issue(enc_r(7'h01, rs2, rs1, f3, pick_reg(), kind == 1 ? 7'h33 : 7'h3b), 64'd0, 64'd0);
      end
      4: begin
        f3 = 3'($urandom);
        if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, f3 == 3'd5 && imm[11], 4'd0, imm[5:0]};
        issue(enc_i(imm, rs1, f3, pick_reg(), 7'h13), 64'd0, 64'd0);
      end
      default: begin
        f3 = ($urandom_range(1, 0) == 0) ? 3'd0 : ($urandom_range(1, 0) == 0 ? 3'd1 : 3'd5);
        if (f3 != 3'd0) imm = {1'b0, f3 == 3'd5 && imm[11], 5'd0, imm[4:0]};
        issue(enc_i(imm, rs1, f3, pick_reg(), 7'h1b), 64'd0, 64'd0);
      end
    endcase
  endtask

  // compare process
  always @(posedge i_clk) begin
    exp_t e;
    if (i_arst_n && o_valid !== valid_d) begin
      $display("FAIL %s o_valid expected %0b actual %0b", test_name, valid_d, o_valid);
      errors = errors + 1;
    end
    valid_d = i_valid;
    if (o_valid) begin
      if (exp_q.size() == 0) begin
        $display("ERROR in %s: o_valid high with no instruction outstanding", test_name);
        errors = errors + 1;
      end else begin
        e = exp_q.pop_front();
        checked = checked + 1;
        if (o_wb_en !== e.wb_en) begin
          $display("FAIL %s wb_en expected %0b actual %0b", test_name, e.wb_en, o_wb_en);
          errors = errors + 1;
        end
        if (e.wb_en && o_rd !== e.rd) begin
          $display("FAIL %s rd expected %0d actual %0d", test_name, e.rd, o_rd);
          errors = errors + 1;
        end
        if (e.wb_en && o_wb_data !== e.wb_data) begin
          $display("FAIL %s wb_data expected %h actual %h", test_name, e.wb_data, o_wb_data);
          errors = errors + 1;
        end
        if (o_next_pc !== e.next_pc) begin
          $display("FAIL %s next_pc expected %h actual %h", test_name, e.next_pc, o_next_pc);
          errors = errors + 1;
        end
        if (o_halt !== e.halt || o_illegal !== e.illegal) begin
          $display("FAIL %s flags expected %0b%0b actual %0b%0b", test_name, e.halt,
                   e.illegal, o_halt, o_illegal);
          errors = errors + 1;
        end
      end
    end
  end

  always @(posedge i_clk) begin
    if (run_started) cycles = cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout: the DUT did not return all results within %0d cycles", LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int err_start;
    logic [63:0] v;
    void'($urandom(54332));
    i_arst_n    = 1'b0;
    i_valid     = 1'b0;
    i_inst      = 32'd0;
    i_pc        = 64'd0;
    i_rdata     = 64'd0;
    errors      = 0;
    checked     = 0;
    cycles      = 0;
    run_started = 1'b0;
    sticky_halt = 1'b0;
    sticky_ill  = 1'b0;
    last_rd     = 5'd0;
    valid_d     = 1'b0;
    test_name   = "reset";
    for (int i = 0; i < 32; i++) shadow[i] = 64'd0;
    repeat (4) @(posedge i_clk);
    i_arst_n <= 1'b1;
    @(posedge i_clk);
    run_started = 1'b1;
    if (o_valid !== 1'b0 || o_wb_en !== 1'b0 || o_halt !== 1'b0 || o_illegal !== 1'b0) begin
      $display("ERROR: outputs not cleared after reset");
      errors = errors + 1;
    end
    $display("test %s: %0d errors", test_name, errors);

    test_name = "init_lui_addi";
    err_start = errors;
    for (int r = 1; r < 32; r++) begin
      v = {$urandom, $urandom};
      issue({v[19:0], 5'(r), 7'h37}, 64'd0, 64'd0);
      issue(enc_i(v[31:20], 5'(r), 3'd0, 5'(r), 7'h13), 64'd0, 64'd0);
    end
    finish_test(err_start, N_INIT);

    test_name = "alu_random";
    err_start = errors;
    for (int n = 0; n < N_ALU; n++) random_alu();
    finish_test(err_start, N_ALU);

    test_name = "branch_jump";
    err_start = errors;
    for (int n = 0; n < N_BRANCH; n++) begin
      v = {$urandom, $urandom} & ~64'd3;
      case ($urandom_range(3, 0))
        0: issue(enc_j(21'($urandom) & ~21'd1, pick_reg()), v, 64'd0);
        1: issue(enc_i(12'($urandom), pick_reg(), 3'd0, pick_reg(), 7'h67), v, 64'd0);
        default: begin
          logic [2:0] bf;
          logic [4:0] r1;
          bf = 3'($urandom_range(5, 0));
          if (bf > 3'd1) bf = bf + 3'd2;
          r1 = pick_reg();
          issue(enc_b(13'($urandom) & ~13'd1, ($urandom_range(3, 0) == 0) ? r1 : pick_reg(),
                      r1, bf), v, 64'd0);
        end
      endcase
    end
    finish_test(err_start, N_BRANCH);

    test_name = "load_extend";
    err_start = errors;
    for (int n = 0; n < N_LOAD - 2; n++) begin
      issue(enc_i(12'($urandom), pick_reg(), 3'($urandom_range(6, 0)), pick_reg(), 7'h03),
            64'd0, {$urandom, $urandom});
    end
    issue(enc_i(12'd0, 5'd1, 3'd3, 5'd0, 7'h03), 64'd0, 64'hdead_beef_0123_4567);
    issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd7, 7'h33), 64'd0, 64'd0);
    finish_test(err_start, N_LOAD);

    test_name = "halt_illegal";
    err_start = errors;
    issue(32'h0010_0073, 64'h100, 64'd0);
    issue(enc_i(12'd5, 5'd0, 3'd0, 5'd3, 7'h13), 64'h104, 64'd0);
    issue(32'hffff_ffff, 64'h108, 64'd0);
    issue(enc_i(12'd9, 5'd3, 3'd0, 5'd4, 7'h13), 64'h10c, 64'd0);
    issue(enc_r(7'h00, 5'd4, 5'd3, 3'd0, 5'd5, 7'h33), 64'h110, 64'd0);
    issue(32'h0000_0000, 64'h114, 64'd0);
    finish_test(err_start, N_FLAGS);

    $display("checked %0d results, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hdl/rv_exec_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/exec_unit.sv
hdl/writeback_unit.sv
hdl/exec_core_top.sv
bench/tb_exec_core.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_exec_core
RTL_TOP   ?= exec_core_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
RTL_SRCS  ?= hdl/rv_exec_pkg.sv hdl/inst_decoder.sv hdl/reg_file.sv hdl/alu.sv \
             hdl/exec_unit.sv hdl/writeback_unit.sv hdl/exec_core_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
